// File: design/sys_pkg.sv
`default_nettype none

package sys_pkg;

	// Bus word types
	typedef logic [31:0] addr_t;	// Byte address
	typedef logic [31:0] data_t;	// Data word

	// RAM word index, address bits 11:2
	typedef logic [9:0] ram_idx_t;

	// Terminal word, bit 8 is the valid flag
	typedef logic [8:0] term_word_t;

	// Bus masters and their req/ack bit positions
	localparam int N_MASTERS = 2;
	localparam int PORT_DATA = 0;	// Data port wins ties
	localparam int PORT_INSN = 1;	// Instruction port

	// Address map
	localparam int RAM_WORDS = 1024;	// Aliases above this
	localparam int TERM_SEL_BIT = 31;	// Set selects terminal

	// Arbiter owner state
	typedef enum logic [1:0]
	{
		ARB_IDLE,	// No owner, grant next
		ARB_DATA,	// Data port owns bus
		ARB_INSN	// Instruction port owns bus
	} arb_state_t;

	// Master port sequencing
	typedef enum logic [1:0]
	{
		PS_IDLE,	// Waiting for Wishbone strobe
		PS_REQ,		// Request raised, no grant yet
		PS_XFER,	// Strobe on bus until ready
		PS_DONE		// Wishbone ack cycle
	} port_state_t;

endpackage

`default_nettype wire

// File: design/sys_bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module sys_bus_arbiter
	import sys_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [N_MASTERS-1:0] bus_req,	// One bit per master
	output logic [N_MASTERS-1:0] bus_ack	// One-hot grant or zero
);

	arb_state_t state;	// Current owner
	arb_state_t state_nxt;

	// Owner selection
	always_comb
	begin
		state_nxt = state;	// Hold by default
		case (state)
			ARB_IDLE:
			begin
				if (bus_req[PORT_DATA])
					state_nxt = ARB_DATA;	// Fixed priority
				else if (bus_req[PORT_INSN])
					state_nxt = ARB_INSN;
			end
			ARB_DATA:
			begin
				if (!bus_req[PORT_DATA])
					state_nxt = ARB_IDLE;	// Released
			end
			ARB_INSN:
			begin
				if (!bus_req[PORT_INSN])
					state_nxt = ARB_IDLE;	// Released
			end
			default:
				state_nxt = ARB_IDLE;
		endcase
	end

	// Grant register
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= ARB_IDLE;
		else
			state <= state_nxt;
	end

	// Grant decode straight from state
	always_comb
	begin
		bus_ack = '0;
		bus_ack[PORT_DATA] = (state == ARB_DATA);
		bus_ack[PORT_INSN] = (state == ARB_INSN);
	end

endmodule

`default_nettype wire

// File: design/sys_master_port.sv
`timescale 1ns/1ps
`default_nettype none

module sys_master_port
	import sys_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	// Wishbone classic slave side
	input  logic  cyc,
	input  logic  stb,
	input  logic  we,
	input  addr_t adr,
	input  data_t dat_w,
	output data_t dat_r,
	output logic  ack,
	// Shared bus master side
	output logic  bus_req,
	input  logic  bus_ack,
	output addr_t bus_addr,
	output data_t bus_wdata,
	output logic  bus_rd,
	output logic  bus_wr,
	input  data_t bus_rdata,
	input  logic  bus_ready
);

	port_state_t state;
	port_state_t state_nxt;

	addr_t adr_q;		// Latched address
	data_t wdata_q;		// Latched write data
	logic  we_q;		// Latched direction
	data_t rdata_q;		// Captured read data

	logic  start;		// New Wishbone cycle
	logic  xfer;		// Strobe phase on bus

	assign start = cyc && stb && (state == PS_IDLE);
	assign xfer  = (state == PS_XFER);

	// Sequencer
	always_comb
	begin
		state_nxt = state;
		case (state)
			PS_IDLE:
				if (cyc && stb)
					state_nxt = PS_REQ;	// Request next cycle
			PS_REQ:
				if (bus_ack)
					state_nxt = PS_XFER;	// Granted
			PS_XFER:
				if (bus_ready)
					state_nxt = PS_DONE;	// Slave answered
			PS_DONE:
				state_nxt = PS_IDLE;	// Ack lasts one cycle
			default:
				state_nxt = PS_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= PS_IDLE;
		else
			state <= state_nxt;
	end

	// Request latch at cycle start
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			adr_q   <= adr;
			wdata_q <= dat_w;
			we_q    <= we;
		end
	end

	// Read data capture on ready
	always_ff @(posedge clk)
	begin
		if (xfer && bus_ready && !we_q)
			rdata_q <= bus_rdata;
	end

	// Wired-OR bus, zero unless transferring
	assign bus_req   = (state == PS_REQ) || xfer;	// Dropped in PS_DONE
	assign bus_addr  = xfer ? adr_q : '0;
	assign bus_wdata = xfer ? wdata_q : '0;
	assign bus_rd    = xfer && !we_q;
	assign bus_wr    = xfer && we_q;

	// Wishbone return
	assign ack   = (state == PS_DONE);
	assign dat_r = rdata_q;

endmodule

`default_nettype wire

// File: design/sys_blockram.sv
`timescale 1ns/1ps
`default_nettype none

module sys_blockram
	import sys_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  addr_t bus_addr,
	input  data_t bus_wdata,
	input  logic  bus_rd,
	input  logic  bus_wr,
	output data_t bus_rdata,
	output logic  bus_ready
);

	data_t    mem [RAM_WORDS];	// Storage
	ram_idx_t idx;			// Word index
	logic     hit;			// Address is ours
	logic     access;		// Fresh strobe cycle
	logic     ready_q;		// One-cycle response
	data_t    rdata_q;		// Registered read word

	// Low word index, upper bits alias
	assign idx = bus_addr[$bits(ram_idx_t)+1:2];
	assign hit = !bus_addr[TERM_SEL_BIT];

	// Second strobe cycle sees ready_q and is ignored
	assign access = hit && (bus_rd || bus_wr) && !ready_q;

	// Write port
	always_ff @(posedge clk)
	begin
		if (access && bus_wr)
			mem[idx] <= bus_wdata;
	end

	// Read port
	always_ff @(posedge clk)
	begin
		if (access && bus_rd)
			rdata_q <= mem[idx];
	end

	// Ready pulse one cycle after strobe
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			ready_q <= 1'b0;
		else
			ready_q <= access;
	end

	// Drive wired-OR bus only while answering
	assign bus_ready = ready_q;
	assign bus_rdata = ready_q ? rdata_q : '0;

endmodule

`default_nettype wire

// File: design/sys_terminal.sv
`timescale 1ns/1ps
`default_nettype none

module sys_terminal
	import sys_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  addr_t      bus_addr,
	input  data_t      bus_wdata,
	input  logic       bus_rd,
	input  logic       bus_wr,
	output data_t      bus_rdata,
	output logic       bus_ready,
	output term_word_t sys_odata,	// Bit 8 marks a pending char
	input  logic       sys_tookdata,	// Host took the char
	input  term_word_t sys_idata	// Host input word
);

	term_word_t odata_q;	// Outgoing char and valid
	data_t      rdata_q;	// Registered read word
	logic       ready_q;	// One-cycle response
	logic       hit;	// Address is ours
	logic       pending;	// Char not yet taken
	logic       wr_go;	// Write accepted now
	logic       rd_go;	// Read accepted now

	assign hit     = bus_addr[TERM_SEL_BIT];
	assign pending = odata_q[8];

	// Writes stall while a char is pending
	assign wr_go = hit && bus_wr && !ready_q && !pending;
	assign rd_go = hit && bus_rd && !ready_q;

	// Output char register
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			odata_q <= '0;
		else if (wr_go)
			odata_q <= {1'b1, bus_wdata[7:0]};	// Set valid
		else if (sys_tookdata)
			odata_q[8] <= 1'b0;	// Host consumed it
	end

	// Read word, zeroed on writes
	always_ff @(posedge clk)
	begin
		if (rd_go)
			rdata_q <= data_t'(sys_idata);	// Zero-extend
		else if (wr_go)
			rdata_q <= '0;
	end

	// Ready one cycle after acceptance
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			ready_q <= 1'b0;
		else
			ready_q <= wr_go || rd_go;
	end

	assign bus_ready = ready_q;
	assign bus_rdata = ready_q ? rdata_q : '0;	// Quiet on wired-OR
	assign sys_odata = odata_q;

endmodule

`default_nettype wire

// File: design/sys_top.sv
`timescale 1ns/1ps
`default_nettype none

module sys_top
	import sys_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	// Instruction port
	input  logic       ib_cyc,
	input  logic       ib_stb,
	input  logic       ib_we,
	input  addr_t      ib_adr,
	input  data_t      ib_dat_w,
	output data_t      ib_dat_r,
	output logic       ib_ack,
	// Data port
	input  logic       db_cyc,
	input  logic       db_stb,
	input  logic       db_we,
	input  addr_t      db_adr,
	input  data_t      db_dat_w,
	output data_t      db_dat_r,
	output logic       db_ack,
	// Host terminal
	output term_word_t sys_odata,
	input  logic       sys_tookdata,
	input  term_word_t sys_idata
);

	logic [N_MASTERS-1:0] bus_req;	// Per-master request
	logic [N_MASTERS-1:0] bus_ack;	// Per-master grant

	// Combined bus
	addr_t bus_addr;
	data_t bus_wdata;
	data_t bus_rdata;
	logic  bus_rd;
	logic  bus_wr;
	logic  bus_ready;

	// Master copies
	addr_t bus_addr_data, bus_addr_insn;
	data_t bus_wdata_data, bus_wdata_insn;
	logic  bus_rd_data, bus_rd_insn;
	logic  bus_wr_data, bus_wr_insn;

	// Slave copies
	data_t bus_rdata_ram, bus_rdata_term;
	logic  bus_ready_ram, bus_ready_term;

	// Wired-OR, idle agents drive zero
	assign bus_addr  = bus_addr_data | bus_addr_insn;
	assign bus_wdata = bus_wdata_data | bus_wdata_insn;
	assign bus_rd    = bus_rd_data | bus_rd_insn;
	assign bus_wr    = bus_wr_data | bus_wr_insn;
	assign bus_rdata = bus_rdata_ram | bus_rdata_term;
	assign bus_ready = bus_ready_ram | bus_ready_term;

	sys_bus_arbiter i_arbiter (
		.clk(clk), .rst_n(rst_n), .bus_req(bus_req), .bus_ack(bus_ack)
	);

	sys_master_port i_port_data (
		.clk(clk), .rst_n(rst_n),
		.cyc(db_cyc), .stb(db_stb), .we(db_we), .adr(db_adr),
		.dat_w(db_dat_w), .dat_r(db_dat_r), .ack(db_ack),
		.bus_req(bus_req[PORT_DATA]), .bus_ack(bus_ack[PORT_DATA]),	// Priority slot
		.bus_addr(bus_addr_data), .bus_wdata(bus_wdata_data),
		.bus_rd(bus_rd_data), .bus_wr(bus_wr_data),
		.bus_rdata(bus_rdata), .bus_ready(bus_ready)
	);

	sys_master_port i_port_insn (
		.clk(clk), .rst_n(rst_n),
		.cyc(ib_cyc), .stb(ib_stb), .we(ib_we), .adr(ib_adr),
		.dat_w(ib_dat_w), .dat_r(ib_dat_r), .ack(ib_ack),
		.bus_req(bus_req[PORT_INSN]), .bus_ack(bus_ack[PORT_INSN]),
		.bus_addr(bus_addr_insn), .bus_wdata(bus_wdata_insn),
		.bus_rd(bus_rd_insn), .bus_wr(bus_wr_insn),
		.bus_rdata(bus_rdata), .bus_ready(bus_ready)
	);

	sys_blockram i_blockram (
		.clk(clk), .rst_n(rst_n),
		.bus_addr(bus_addr), .bus_wdata(bus_wdata),
		.bus_rd(bus_rd), .bus_wr(bus_wr),
		.bus_rdata(bus_rdata_ram), .bus_ready(bus_ready_ram)
	);

	sys_terminal i_terminal (
		.clk(clk), .rst_n(rst_n),
		.bus_addr(bus_addr), .bus_wdata(bus_wdata),
		.bus_rd(bus_rd), .bus_wr(bus_wr),
		.bus_rdata(bus_rdata_term), .bus_ready(bus_ready_term),
		.sys_odata(sys_odata), .sys_tookdata(sys_tookdata), .sys_idata(sys_idata)
	);

endmodule

`default_nettype wire

// File: testbench/sys_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sys_tb
	import sys_pkg::*;
();

	localparam int MAX_CYCLES = 4000;	// About 60 transactions of up to 20 cycles plus margin
	localparam int N_WRITES   = 16;
	localparam int N_READS    = 16;
	localparam int N_INSN     = 12;
	localparam int N_RACES    = 4;

	logic       clk;
	logic       rst_n;
	logic       ib_cyc;
	logic       ib_stb;
	logic       ib_we;
	addr_t      ib_adr;
	data_t      ib_dat_w;
	data_t      ib_dat_r;
	logic       ib_ack;
	logic       db_cyc;
	logic       db_stb;
	logic       db_we;
	addr_t      db_adr;
	data_t      db_dat_w;
	data_t      db_dat_r;
	logic       db_ack;
	term_word_t sys_odata;
	logic       sys_tookdata;
	term_word_t sys_idata;

	data_t    ref_mem [RAM_WORDS];	// Reference RAM
	ram_idx_t written [$];		// Indices with known contents
	int       err_value = 0;	// Wrong data
	int       err_proto = 0;	// Handshake or ordering faults
	int       cycles = 0;
	string    test_name = "none";

	sys_top i_sys_top (
		.clk(clk), .rst_n(rst_n),
		.ib_cyc(ib_cyc), .ib_stb(ib_stb), .ib_we(ib_we), .ib_adr(ib_adr),
		.ib_dat_w(ib_dat_w), .ib_dat_r(ib_dat_r), .ib_ack(ib_ack),
		.db_cyc(db_cyc), .db_stb(db_stb), .db_we(db_we), .db_adr(db_adr),
		.db_dat_w(db_dat_w), .db_dat_r(db_dat_r), .db_ack(db_ack),
		.sys_odata(sys_odata), .sys_tookdata(sys_tookdata), .sys_idata(sys_idata)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;	// 4 ns period
	end

	// Ack only inside a strobe and for one cycle
	assert property (@(posedge clk) disable iff (!rst_n) db_ack |-> db_stb ##1 !db_ack)
	else
	begin
		err_proto++;
		$display("Protocol error: db_ack outside a strobe or longer than one cycle");
	end

	assert property (@(posedge clk) disable iff (!rst_n) ib_ack |-> ib_stb ##1 !ib_ack)
	else
	begin
		err_proto++;
		$display("Protocol error: ib_ack outside a strobe or longer than one cycle");
	end

	// Only the granted master strobes the shared bus
	assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({i_sys_top.bus_rd_data | i_sys_top.bus_wr_data,
			i_sys_top.bus_rd_insn | i_sys_top.bus_wr_insn}))
	else
	begin
		err_proto++;
		$display("Protocol error: both masters drove the shared bus at once");
	end

	task automatic check_value(input data_t exp, input data_t act);
		assert (act === exp)
		else
		begin
			err_value++;
			$display("** Error %s: expected %h, actual %h", test_name, exp, act);
		end
	endtask

	// Sets or clears one Wishbone port where insn picks the instruction side
	task automatic drive_port(input bit insn, input logic on, input logic we,
		input addr_t adr, input data_t wdat);
		if (insn)
		begin
			ib_cyc   <= on;
			ib_stb   <= on;
			ib_we    <= we;
			ib_adr   <= adr;
			ib_dat_w <= wdat;
		end
		else
		begin
			db_cyc   <= on;
			db_stb   <= on;
			db_we    <= we;
			db_adr   <= adr;
			db_dat_w <= wdat;
		end
	endtask

	task automatic run_cycle(input bit insn, input logic we, input addr_t adr,
		input data_t wdat, output data_t rdat);
		@(posedge clk);
		drive_port(insn, 1'b1, we, adr, wdat);
		do
			@(negedge clk);
		while (!(insn ? ib_ack : db_ack));	// Latency set by arbitration
		rdat = insn ? ib_dat_r : db_dat_r;
		@(posedge clk);
		drive_port(insn, 1'b0, 1'b0, '0, '0);	// Drop stb after ack
	endtask

	// Both ports start a read on the same edge and report their ack cycles
	task automatic race_reads(input addr_t adr_d, input addr_t adr_i, output data_t rd_d,
		output data_t rd_i, output int t_d, output int t_i);
		bit seen_d;
		bit seen_i;
		t_d = 0;
		t_i = 0;
		@(posedge clk);
		drive_port(1'b0, 1'b1, 1'b0, adr_d, '0);
		drive_port(1'b1, 1'b1, 1'b0, adr_i, '0);
		while (t_d == 0 || t_i == 0)
		begin
			@(negedge clk);
			seen_d = db_ack;
			seen_i = ib_ack;
			if (seen_d)
			begin
				t_d  = cycles;
				rd_d = db_dat_r;
			end
			if (seen_i)
			begin
				t_i  = cycles;
				rd_i = ib_dat_r;
			end
			@(posedge clk);
			if (seen_d)
				drive_port(1'b0, 1'b0, 1'b0, '0, '0);
			if (seen_i)
				drive_port(1'b1, 1'b0, 1'b0, '0, '0);
		end
	endtask

	// RAM address for a word index with random aliasing upper bits
	function automatic addr_t alias_addr(input ram_idx_t idx);
		addr_t a;
		a = $urandom;
		a[TERM_SEL_BIT] = 1'b0;
		a[11:2] = idx;
		a[1:0]  = 2'b00;
		return a;
	endfunction

	initial
	begin
		data_t    rdat;
		data_t    rd_i;
		data_t    wdat;
		addr_t    adr;
		ram_idx_t idx;
		ram_idx_t idx_i;
		int       t_d;
		int       t_i;
		term_word_t host_word;

		void'($urandom(98));
		rst_n        = 1'b0;
		sys_tookdata = 1'b0;
		sys_idata    = '0;
		drive_port(1'b0, 1'b0, 1'b0, '0, '0);
		drive_port(1'b1, 1'b0, 1'b0, '0, '0);
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;

		test_name = "reset";
		repeat (4)
		begin
			@(negedge clk);
			assert (!ib_ack && !db_ack && !sys_odata[8] && i_sys_top.bus_req == '0
				&& i_sys_top.bus_ack == '0)
			else
			begin
				err_proto++;
				$display("Reset error: an ack, request, grant or output valid is high");
			end
		end

		test_name = "data_write";
		for (int i = 0; i < N_WRITES; i++)
		begin
			idx  = ram_idx_t'($urandom);
			wdat = $urandom;
			run_cycle(1'b0, 1'b1, alias_addr(idx), wdat, rdat);
			ref_mem[idx] = wdat;	// Model follows every write
			written.push_back(idx);
		end

		test_name = "data_read";
		for (int i = 0; i < N_READS; i++)
		begin
			idx = written[$urandom_range(written.size() - 1)];
			run_cycle(1'b0, 1'b0, alias_addr(idx), '0, rdat);	// Fresh alias each time
			check_value(ref_mem[idx], rdat);
		end

		test_name = "insn_read";
		for (int i = 0; i < N_INSN; i++)
		begin
			idx = written[$urandom_range(written.size() - 1)];
			run_cycle(1'b1, 1'b0, alias_addr(idx), '0, rdat);
			check_value(ref_mem[idx], rdat);
		end

		test_name = "race";
		for (int i = 0; i < N_RACES; i++)
		begin
			idx   = written[$urandom_range(written.size() - 1)];
			idx_i = written[$urandom_range(written.size() - 1)];
			race_reads(alias_addr(idx), alias_addr(idx_i), rdat, rd_i, t_d, t_i);
			assert (t_d < t_i)
			else
			begin
				err_proto++;
				$display("Arbitration error: instruction ack came before data ack");
			end
			check_value(ref_mem[idx], rdat);
			check_value(ref_mem[idx_i], rd_i);
		end

		test_name = "term_write";
		adr  = $urandom;
		adr[TERM_SEL_BIT] = 1'b1;
		wdat = $urandom;
		run_cycle(1'b0, 1'b1, adr, wdat, rdat);
		check_value({23'b0, 1'b1, wdat[7:0]}, data_t'(sys_odata));	// Byte plus valid

		test_name = "term_stall";
		wdat = $urandom;
		@(posedge clk);
		drive_port(1'b0, 1'b1, 1'b1, adr, wdat);
		repeat (20)
		begin
			@(negedge clk);
			assert (!db_ack)
			else
			begin
				err_proto++;
				$display("Back-pressure error: terminal write acked before the host took data");
			end
		end
		@(posedge clk);
		sys_tookdata <= 1'b1;	// Host takes the first char
		@(posedge clk);
		sys_tookdata <= 1'b0;
		do
			@(negedge clk);
		while (!db_ack);
		@(posedge clk);
		drive_port(1'b0, 1'b0, 1'b0, '0, '0);
		check_value({23'b0, 1'b1, wdat[7:0]}, data_t'(sys_odata));

		test_name = "term_read";
		host_word = term_word_t'($urandom);
		@(posedge clk);
		sys_idata <= host_word;
		adr = $urandom;
		adr[TERM_SEL_BIT] = 1'b1;
		run_cycle(1'b0, 1'b0, adr, '0, rdat);
		check_value({23'b0, host_word}, rdat);

		$display("Run complete: %0d value errors, %0d protocol errors", err_value, err_proto);
		if (err_value + err_proto == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	// Watchdog
	initial
	begin
		while (cycles < MAX_CYCLES)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
		$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: sys_bus.f
design/sys_pkg.sv
design/sys_bus_arbiter.sv
design/sys_master_port.sv
design/sys_blockram.sv
design/sys_terminal.sv
design/sys_top.sv
testbench/sys_tb.sv

// File: Bender.yml
package:
  name: sys_bus

sources:
  - design/sys_pkg.sv
  - design/sys_bus_arbiter.sv
  - design/sys_master_port.sv
  - design/sys_blockram.sv
  - design/sys_terminal.sv
  - design/sys_top.sv
  - target: test
    files:
      - testbench/sys_tb.sv
